// File: bench/spi_checker.sv
// testbench checker
// samples miso and apb responses against the expected bytes of each test
`timescale 1ns/100ps
`default_nettype none

module spi_checker (
   input  wire        sclk,
   input  wire        spi_sck,
   input  wire        spi_ss_n,
   input  wire        spi_miso,
   input  wire        psel,
   input  wire        penable,
   input  wire        pwrite,
   input  wire [7:0]  prdata,
   input  wire        pready,
   input  wire        pslverr,
   input  wire        start,       // single cycle pulse with the test info valid
   input  wire        done,        // single cycle pulse at test end
   input  wire [7:0]  test_idx,
   input  wire [2:0]  n_apb,       // apb accesses expected
   input  wire [2:0]  n_miso,      // miso bytes to compare
   input  wire        cpol,
   input  wire        lsbfirst,
   input  wire        exp_err,
   input  wire [31:0] exp_bytes,   // first byte in the top bits
   output int         fail_count,
   output int         error_count
);

   int         errs;               // errors in the running test
   int         apb_seen;
   int         spi_bits;           // sampling edges since select
   int         miso_seen;
   logic       sck_q;
   logic [7:0] rx;
   logic [7:0] want;

   task automatic value_error(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
      $display("Error: test %0d %s = 0x%02h, expected 0x%02h", test_idx, name, got, exp);
      errs++;
   endtask

   initial begin
      fail_count  = 0;
      error_count = 0;
      errs        = 0;
      apb_seen    = 0;
      spi_bits    = 0;
      miso_seen   = 0;
      rx          = '0;
      sck_q       = 1'b0;
   end

   always @(posedge sclk) begin
      sck_q <= spi_sck;
      if (start) begin
         errs      = 0;
         apb_seen  = 0;
         miso_seen = 0;
      end

      //####################
      // apb access phase
      if (psel && penable) begin
         want = (apb_seen < 4) ? exp_bytes[31 - 8*apb_seen -: 8] : 8'h00;
         if (pready !== 1'b1)
            value_error("pready", {7'b0, pready}, 8'h01);
         if (pslverr !== exp_err)
            value_error("pslverr", {7'b0, pslverr}, {7'b0, exp_err});
         if (!pwrite && prdata !== want)
            value_error("prdata", prdata, want);
         apb_seen++;
      end

      //####################
      // spi master side samples miso on the sampling edge
      if (spi_ss_n) begin
         spi_bits = 0;
      end else if ((spi_sck ^ cpol) && !(sck_q ^ cpol)) begin
         if (spi_bits >= 8) begin   // past the command byte
            rx = lsbfirst ? {spi_miso, rx[7:1]} : {rx[6:0], spi_miso};
            if (spi_bits % 8 == 7 && miso_seen < n_miso) begin
               want = exp_bytes[31 - 8*miso_seen -: 8];
               if (rx !== want)
                  value_error("spi_miso byte", rx, want);
               miso_seen++;
            end
         end
         spi_bits++;
      end

      if (done) begin
         if (apb_seen != n_apb) begin
            $display("test %0d: saw %0d APB accesses but expected %0d",
                     test_idx, apb_seen, n_apb);
            errs++;
         end
         if (errs == 0)
            $display("test %0d: ok", test_idx);
         else begin
            $display("test %0d: failed with %0d errors", test_idx, errs);
            fail_count++;
         end
         error_count += errs;
      end
   end

endmodule

`default_nettype wire

// File: bench/spi_clock_gen.sv
// testbench clock and reset
// free running sclk, nreset low for the first few cycles
`timescale 1ns/100ps
`default_nettype none

module spi_clock_gen #(
   parameter real PERIOD       = 100.0,
   parameter int  RESET_CYCLES = 3
) (
   output logic sclk,
   output logic nreset
);

   initial begin
      sclk   = 1'b0;
      nreset = 1'b0;                          // in reset from time zero
      repeat (RESET_CYCLES) @(posedge sclk);
      nreset <= 1'b1;
   end

   always #(PERIOD / 2.0) sclk = ~sclk;

endmodule

`default_nettype wire

// File: bench/tb_top.sv
// testbench top
// table of apb and spi transfers run against the spi register block
`include "spi_defs.svh"
`timescale 1ns/100ps
`default_nettype none

module tb_top;

   localparam int NTESTS   = 28;          // entries in the table
   localparam int HALF_SCK = 8;           // sclk cycles per sck half period
   localparam int K_APB_WR = 0;
   localparam int K_APB_RD = 1;
   localparam int K_SPI    = 2;
   localparam logic [1:0] OPX    = 2'b00; // opcode unused on apb entries
   localparam logic [1:0] OP_WR  = spi_cmd_pkg::OP_WRITE;
   localparam logic [1:0] OP_RD  = spi_cmd_pkg::OP_READ;
   localparam logic [1:0] OP_FET = spi_cmd_pkg::OP_FETCH;
   localparam logic [1:0] OP_NOP = spi_cmd_pkg::OP_NOP;

   int          t_kind [NTESTS];
   logic [7:0]  t_addr [NTESTS];
   logic [1:0]  t_op   [NTESTS];
   int          t_n    [NTESTS];
   logic [1:0]  t_mode [NTESTS];         // {lsbfirst, cpol}
   logic [31:0] t_data [NTESTS];         // first byte in the top bits
   logic [31:0] t_exp  [NTESTS];
   logic        t_err  [NTESTS];
   int          n_fill;

   logic               sclk, nreset;
   logic               spi_sck, spi_mosi, spi_ss_n, spi_miso;
   logic [`APB_AW-1:0] paddr;
   logic               psel, penable, pwrite, pready, pslverr;
   logic [7:0]         pwdata, prdata;
   logic               start, done, cur_cpol, cur_lsb, cur_err;
   logic [7:0]         cur_idx;
   logic [2:0]         cur_apb, cur_miso;
   logic [31:0]        cur_exp, burst;
   int                 fail_count, error_count;

   spi_clock_gen #(.PERIOD(100.0), .RESET_CYCLES(3)) spi_clock_gen_inst (
      .sclk   (sclk),
      .nreset (nreset)
   );

   spi_reg_top spi_reg_top_inst (
      .sclk (sclk), .nreset (nreset),
      .spi_sck (spi_sck), .spi_mosi (spi_mosi), .spi_ss_n (spi_ss_n), .spi_miso (spi_miso),
      .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
      .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr)
   );

   spi_checker spi_checker_inst (
      .sclk (sclk), .spi_sck (spi_sck), .spi_ss_n (spi_ss_n), .spi_miso (spi_miso),
      .psel (psel), .penable (penable), .pwrite (pwrite), .prdata (prdata),
      .pready (pready), .pslverr (pslverr), .start (start), .done (done),
      .test_idx (cur_idx), .n_apb (cur_apb), .n_miso (cur_miso), .cpol (cur_cpol),
      .lsbfirst (cur_lsb), .exp_err (cur_err), .exp_bytes (cur_exp),
      .fail_count (fail_count), .error_count (error_count)
   );

   task automatic add_entry(input int kind, input logic [7:0] addr, input logic [1:0] op,
                            input int n, input logic [1:0] mode, input logic [31:0] data,
                            input logic [31:0] exp, input logic err);
      t_kind[n_fill] = kind;
      t_addr[n_fill] = addr;
      t_op[n_fill]   = op;
      t_n[n_fill]    = n;
      t_mode[n_fill] = mode;
      t_data[n_fill] = data;
      t_exp[n_fill]  = exp;
      t_err[n_fill]  = err;
      n_fill++;
   endtask

   task automatic build_table();
      // reset values while spi is still disabled
      add_entry(K_APB_RD, 8'h00, OPX, 1, 2'b00, 32'h0, {`SPI_ID_VALUE, 24'h0}, 1'b0);
      add_entry(K_APB_RD, `APB_CTRL_ADDR, OPX, 1, 2'b00, 32'h0, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd10, OP_WR, 1, 2'b00, 32'h3C00_0000, 32'h0, 1'b0);
      add_entry(K_APB_RD, 8'd10, OPX,   1, 2'b00, 32'h0, 32'h0, 1'b0);
      // write bursts where the second wraps onto the id byte
      add_entry(K_APB_WR, `APB_CTRL_ADDR, OPX, 1, 2'b00, 32'h0100_0000, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd5,  OP_WR, 4, 2'b00, burst, 32'h0, 1'b0);
      add_entry(K_APB_RD, 8'd5,  OPX,   4, 2'b00, 32'h0, burst, 1'b0);
      add_entry(K_SPI,    8'd63, OP_WR, 2, 2'b00, 32'h7788_0000, 32'h0, 1'b0);
      add_entry(K_APB_RD, 8'd63, OPX,   1, 2'b00, 32'h0, 32'h7700_0000, 1'b0);
      add_entry(K_APB_RD, 8'd0,  OPX,   1, 2'b00, 32'h0, {`SPI_ID_VALUE, 24'h0}, 1'b0);
      // host writes that spi reads back
      add_entry(K_APB_WR, 8'd20, OPX,   4, 2'b00, 32'h1234_5678, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd20, OP_RD, 4, 2'b00, 32'h0, 32'h1234_5678, 1'b0);
      // cpol=1 then lsbfirst=1 round trips
      add_entry(K_APB_WR, `APB_CTRL_ADDR, OPX, 1, 2'b00, 32'h0300_0000, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd30, OP_WR, 3, 2'b01, 32'hC1C2_C300, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd30, OP_RD, 3, 2'b01, 32'h0, 32'hC1C2_C300, 1'b0);
      add_entry(K_APB_WR, `APB_CTRL_ADDR, OPX, 1, 2'b00, 32'h0500_0000, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd40, OP_WR, 2, 2'b10, 32'h814E_0000, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd40, OP_RD, 2, 2'b10, 32'h0, 32'h814E_0000, 1'b0);
      add_entry(K_APB_RD, 8'd40, OPX,   2, 2'b00, 32'h0, 32'h814E_0000, 1'b0);
      // slave errors and no-op commands
      add_entry(K_APB_WR, `APB_CTRL_ADDR, OPX, 1, 2'b00, 32'h0100_0000, 32'h0, 1'b0);
      add_entry(K_APB_WR, 8'h41, OPX,   1, 2'b00, 32'h5500_0000, 32'h0, 1'b1);
      add_entry(K_APB_RD, 8'h41, OPX,   1, 2'b00, 32'h0, 32'h0, 1'b1);
      add_entry(K_APB_WR, 8'h00, OPX,   1, 2'b00, 32'h5A00_0000, 32'h0, 1'b1);
      add_entry(K_APB_RD, 8'h00, OPX,   1, 2'b00, 32'h0, {`SPI_ID_VALUE, 24'h0}, 1'b0);
      add_entry(K_APB_RD, 8'h01, OPX,   1, 2'b00, 32'h0, 32'h0, 1'b0);   // 0x41 alias
      add_entry(K_SPI,    8'd20, OP_FET, 1, 2'b00, 32'hEE00_0000, 32'h0, 1'b0);
      add_entry(K_SPI,    8'd21, OP_NOP, 1, 2'b00, 32'hEE00_0000, 32'h0, 1'b0);
      add_entry(K_APB_RD, 8'd20, OPX,   2, 2'b00, 32'h0, 32'h1234_0000, 1'b0);
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [7:0] data);
      @(posedge sclk);
      psel    <= 1'b1;                     // setup phase
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge sclk);
      penable <= 1'b1;                     // access phase
      @(posedge sclk);
      while (!pready)
         @(posedge sclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic spi_send_byte(input logic [7:0] b, input logic cp, input logic lsb);
      for (int i = 0; i < 8; i++) begin
         spi_mosi <= lsb ? b[i] : b[7-i];
         spi_sck  <= cp;                   // shifting edge back to idle
         repeat (HALF_SCK) @(posedge sclk);
         spi_sck  <= ~cp;                  // sampling edge
         repeat (HALF_SCK) @(posedge sclk);
      end
   endtask

   task automatic spi_transfer(input int idx);
      logic cp;
      logic lsb;
      cp  = t_mode[idx][0];
      lsb = t_mode[idx][1];
      @(posedge sclk);
      spi_sck  <= cp;                      // idle level settles before select
      spi_mosi <= 1'b0;
      repeat (HALF_SCK) @(posedge sclk);
      spi_ss_n <= 1'b0;
      repeat (HALF_SCK) @(posedge sclk);
      spi_send_byte({t_op[idx], t_addr[idx][5:0]}, cp, lsb);
      for (int k = 0; k < t_n[idx]; k++)
         spi_send_byte(t_data[idx][31 - 8*k -: 8], cp, lsb);
      spi_sck <= cp;
      repeat (HALF_SCK) @(posedge sclk);
      spi_ss_n <= 1'b1;
      repeat (HALF_SCK) @(posedge sclk);
   endtask

   task automatic run_entry(input int idx);
      @(posedge sclk);
      cur_idx  <= idx[7:0];
      cur_cpol <= t_mode[idx][0];
      cur_lsb  <= t_mode[idx][1];
      cur_err  <= t_err[idx];
      cur_exp  <= t_exp[idx];
      cur_apb  <= (t_kind[idx] == K_SPI) ? 3'd0 : t_n[idx][2:0];
      cur_miso <= (t_kind[idx] == K_SPI && t_op[idx] == OP_RD) ? t_n[idx][2:0] : 3'd0;
      start    <= 1'b1;
      @(posedge sclk);
      start    <= 1'b0;
      if (t_kind[idx] == K_SPI)
         spi_transfer(idx);
      else
         for (int k = 0; k < t_n[idx]; k++)
            apb_access(t_kind[idx] == K_APB_WR, t_addr[idx] + k[7:0],
                       t_data[idx][31 - 8*k -: 8]);
      @(posedge sclk);
      done <= 1'b1;
      @(posedge sclk);
      done <= 1'b0;
   endtask

   //####################
   // main sequence
   initial begin
      spi_sck  = 1'b0;
      spi_mosi = 1'b0;
      spi_ss_n = 1'b1;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      start    = 1'b0;
      done     = 1'b0;
      cur_idx  = '0;
      cur_apb  = '0;
      cur_miso = '0;
      cur_cpol = 1'b0;
      cur_lsb  = 1'b0;
      cur_err  = 1'b0;
      cur_exp  = '0;
      n_fill   = 0;
      burst    = $urandom(21);             // seeds the run and draws four burst bytes
      build_table();
      @(posedge nreset);
      for (int i = 0; i < n_fill; i++)
         run_entry(i);
      repeat (2) @(posedge sclk);
      $display("%0d tests run, %0d failed, %0d errors", n_fill, fail_count, error_count);
      if (fail_count == 0 && error_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   // watchdog with a budget per table entry
   initial begin
      repeat (NTESTS * 2000) @(posedge sclk);
      $display("timeout: the test table did not complete in %0d clock cycles", NTESTS * 2000);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/apb_host_port.sv
// apb host port
// address decode, control register and register file forwarding
`include "spi_defs.svh"
`timescale 1ns/100ps
`default_nettype none

module apb_host_port (
   input  wire               sclk,
   input  wire               nreset,
   input  wire [`APB_AW-1:0] paddr,
   input  wire               psel,
   input  wire               penable,
   input  wire               pwrite,
   input  wire [`SPI_DW-1:0] pwdata,
   output logic [`SPI_DW-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   output logic              spi_en,
   output logic              cpol,
   output logic              lsbfirst,
   reg_bus_if.requester      bus
);

   logic                  access;     // apb access phase
   logic                  in_regs;    // below the control address
   logic                  is_ctrl;
   logic [2:0]            ctrl_q;     // en, cpol, lsbfirst
   reg_pkg::apb_resp_e    resp;

   assign access  = psel & penable;
   assign in_regs = paddr < `APB_CTRL_ADDR;
   assign is_ctrl = paddr == `APB_CTRL_ADDR;

   // past control reg, or write to the id byte
   assign resp = ((paddr > `APB_CTRL_ADDR) || (pwrite && paddr == '0)) ?
                 reg_pkg::RESP_SLVERR : reg_pkg::RESP_OKAY;

   //####################
   // register bus

   assign bus.wr    = access & pwrite & in_regs & (resp == reg_pkg::RESP_OKAY);
   assign bus.rd    = psel & ~pwrite & in_regs;
   assign bus.addr  = paddr[`SPI_AW-1:0];
   assign bus.wdata = pwdata;

   // control register
   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset)
         ctrl_q <= 3'b000;                     // spi off after reset
      else if (access && pwrite && is_ctrl)
         ctrl_q <= pwdata[2:0];
   end

   assign spi_en   = ctrl_q[reg_pkg::CTRL_EN];
   assign cpol     = ctrl_q[reg_pkg::CTRL_CPOL];
   assign lsbfirst = ctrl_q[reg_pkg::CTRL_LSBFIRST];

   // read mux, zero for bad addresses
   always_comb begin
      if (in_regs)
         prdata = bus.rdata;
      else if (is_ctrl)
         prdata = {{(`SPI_DW-3){1'b0}}, ctrl_q};
      else
         prdata = '0;
   end

   assign pready  = access;                    // never stalls
   assign pslverr = access & (resp == reg_pkg::RESP_SLVERR);

endmodule

`default_nettype wire

// File: hdl/reg_bus_if.sv
// register access bus
// one requester against one register file port, reads are combinational
`include "spi_defs.svh"
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;

   logic               wr;     // single cycle write strobe
   logic               rd;     // read enable, gates rdata
   logic [`SPI_AW-1:0] addr;
   logic [`SPI_DW-1:0] wdata;
   logic [`SPI_DW-1:0] rdata;  // valid same cycle as addr

   // spi engine or apb port side
   modport requester (
      output wr, rd, addr, wdata,
      input  rdata
   );

   // register storage side
   modport regfile (
      input  wr, rd, addr, wdata,
      output rdata
   );

endinterface

`default_nettype wire

// File: hdl/reg_file.sv
// register file
// 64 bytes shared by spi and apb, read-only id at address 0
`include "spi_defs.svh"
`timescale 1ns/100ps
`default_nettype none

module reg_file (
   input  wire         sclk,
   input  wire         nreset,
   reg_bus_if.regfile  spi_port,
   reg_bus_if.regfile  host_port
);

   logic [`SPI_DW-1:0] mem [`SPI_NREGS];
   logic               spi_wr_ok;
   logic               host_wr_ok;

   // address 0 never written
   assign spi_wr_ok  = spi_port.wr & (spi_port.addr != '0);
   // spi has priority, host write lost on a collision
   assign host_wr_ok = host_port.wr & (host_port.addr != '0) & ~spi_port.wr;

   //####################
   // storage

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < `SPI_NREGS; i++)
            mem[i] <= (i == 0) ? `SPI_ID_VALUE : '0;
      end else if (spi_wr_ok) begin
         mem[spi_port.addr] <= spi_port.wdata;
      end else if (host_wr_ok) begin
         mem[host_port.addr] <= host_port.wdata;
      end
   end

   //####################
   // read ports, independent

   assign spi_port.rdata  = spi_port.rd  ? mem[spi_port.addr]  : '0;
   assign host_port.rdata = host_port.rd ? mem[host_port.addr] : '0;

endmodule

`default_nettype wire

// File: hdl/reg_pkg.sv
// register side types
// control register bit map and apb response codes
`default_nettype none

package reg_pkg;

   // bit index into the 3-bit control register
   typedef enum logic [1:0] {
      CTRL_EN       = 2'd0,
      CTRL_CPOL     = 2'd1,
      CTRL_LSBFIRST = 2'd2
   } ctrl_bit_e;

   typedef enum logic {
      RESP_OKAY   = 1'b0,
      RESP_SLVERR = 1'b1
   } apb_resp_e;

endpackage

`default_nettype wire

// File: hdl/spi_cmd_pkg.sv
// spi command types
// opcode field of the command byte and transaction state
`default_nettype none

package spi_cmd_pkg;

   // top two bits of the command byte
   typedef enum logic [1:0] {
      OP_WRITE = 2'b00,
      OP_FETCH = 2'b01,   // remote fetch, no-op here
      OP_READ  = 2'b10,
      OP_NOP   = 2'b11
   } spi_op_e;

   // one transaction = command byte, then data bytes until ss_n rises
   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,    // ss_n high
      ST_CMD  = 2'b01,    // shifting the command byte
      ST_DATA = 2'b10     // data bytes, address auto increments
   } spi_state_e;

endpackage

`default_nettype wire

// File: hdl/spi_defs.svh
// spi register block
// shared widths, register count and fixed addresses
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// register side
`define SPI_AW        6        // register address bits
`define SPI_DW        8        // byte wide data
`define SPI_NREGS     64       // full 6-bit space

// fixed contents at address 0
`define SPI_ID_VALUE  8'hA5

// host side
`define APB_AW        8
`define APB_CTRL_ADDR 8'h40    // first address past the register file

`endif

// File: hdl/spi_reg_top.sv
// spi register block top
// spi slave and apb host sharing one register file
`include "spi_defs.svh"
`timescale 1ns/100ps
`default_nettype none

module spi_reg_top (
   input  wire                sclk,
   input  wire                nreset,
   input  wire                spi_sck,
   input  wire                spi_mosi,
   input  wire                spi_ss_n,
   output logic               spi_miso,
   input  wire [`APB_AW-1:0]  paddr,
   input  wire                psel,
   input  wire                penable,
   input  wire                pwrite,
   input  wire [`SPI_DW-1:0]  pwdata,
   output logic [`SPI_DW-1:0] prdata,
   output logic               pready,
   output logic               pslverr
);

   logic spi_en, cpol, lsbfirst;   // control reg to spi side

   reg_bus_if spi_bus ();
   reg_bus_if host_bus ();

   spi_slave_io spi_slave_io_inst (
      .sclk     (sclk),
      .nreset   (nreset),
      .spi_sck  (spi_sck),
      .spi_mosi (spi_mosi),
      .spi_ss_n (spi_ss_n),
      .spi_miso (spi_miso),
      .spi_en   (spi_en),
      .cpol     (cpol),
      .lsbfirst (lsbfirst),
      .bus      (spi_bus.requester)
   );

   reg_file reg_file_inst (
      .sclk      (sclk),
      .nreset    (nreset),
      .spi_port  (spi_bus.regfile),
      .host_port (host_bus.regfile)
   );

   apb_host_port apb_host_port_inst (
      .sclk     (sclk),
      .nreset   (nreset),
      .paddr    (paddr),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .spi_en   (spi_en),
      .cpol     (cpol),
      .lsbfirst (lsbfirst),
      .bus      (host_bus.requester)
   );

endmodule

`default_nettype wire

// File: hdl/spi_slave_io.sv
// spi slave io
// oversampled pins, command and data fsm, rx and tx shift registers
`include "spi_defs.svh"
`timescale 1ns/100ps
`default_nettype none

module spi_slave_io (
   input  wire           sclk,
   input  wire           nreset,
   input  wire           spi_sck,
   input  wire           spi_mosi,
   input  wire           spi_ss_n,
   output logic          spi_miso,
   input  wire           spi_en,
   input  wire           cpol,
   input  wire           lsbfirst,
   reg_bus_if.requester  bus
);

   logic               sck_s1, sck_s2;     // two flop synchronisers
   logic               mosi_s1, mosi_s2;
   logic               ss_s1, ss_s2;
   logic               sck_p;              // sck after polarity fix
   logic               sck_d;              // one cycle later, for edges
   logic               sample_edge;        // rising edge of sck_p
   logic               shift_edge;         // falling edge of sck_p
   logic [2:0]         bit_cnt;
   logic               byte_end;
   logic               cmd_done;
   logic               data_done;
   spi_cmd_pkg::spi_state_e state;
   spi_cmd_pkg::spi_op_e    op_q;
   spi_cmd_pkg::spi_op_e    cmd_op;
   logic [`SPI_AW-1:0] addr_q;
   logic [`SPI_DW-1:0] rx_sh, rx_next;
   logic [`SPI_DW-1:0] tx_sh;
   logic [`SPI_DW-1:0] wdata_q;
   logic               wr_q, load_q, miso_q;

   //####################
   // pin sampling

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         sck_s1  <= 1'b0;
         sck_s2  <= 1'b0;
         mosi_s1 <= 1'b0;
         mosi_s2 <= 1'b0;
         ss_s1   <= 1'b1;    // deselected
         ss_s2   <= 1'b1;
         sck_d   <= 1'b0;
      end else begin
         sck_s1  <= spi_sck;
         sck_s2  <= sck_s1;
         mosi_s1 <= spi_mosi;
         mosi_s2 <= mosi_s1;
         ss_s1   <= spi_ss_n;
         ss_s2   <= ss_s1;
         sck_d   <= sck_p;
      end
   end

   assign sck_p       = sck_s2 ^ cpol;          // cpol=1 idles high
   assign sample_edge = sck_p & ~sck_d & ~ss_s2;
   assign shift_edge  = ~sck_p & sck_d & ~ss_s2;

   // next rx byte including the bit on this edge
   assign rx_next = lsbfirst ? {mosi_s2, rx_sh[`SPI_DW-1:1]}
                             : {rx_sh[`SPI_DW-2:0], mosi_s2};

   assign byte_end  = sample_edge & (bit_cnt == 3'd7);
   assign cmd_done  = byte_end & (state == spi_cmd_pkg::ST_CMD);
   assign data_done = byte_end & (state == spi_cmd_pkg::ST_DATA);
   assign cmd_op    = spi_cmd_pkg::spi_op_e'(rx_next[`SPI_DW-1:`SPI_AW]);

   //####################
   // command / data fsm

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         state   <= spi_cmd_pkg::ST_IDLE;
         bit_cnt <= 3'd0;
         op_q    <= spi_cmd_pkg::OP_NOP;
         addr_q  <= '0;
         wr_q    <= 1'b0;
         load_q  <= 1'b0;
      end else begin
         wr_q   <= data_done & (op_q == spi_cmd_pkg::OP_WRITE) & spi_en;
         // first load right after the command, then after every data byte
         load_q <= (cmd_done & (cmd_op == spi_cmd_pkg::OP_READ)) |
                   (data_done & (op_q == spi_cmd_pkg::OP_READ));
         if (ss_s2) begin
            state   <= spi_cmd_pkg::ST_IDLE;   // abort at any point
            bit_cnt <= 3'd0;
         end else begin
            if (sample_edge)
               bit_cnt <= bit_cnt + 3'd1;      // wraps every byte
            case (state)
               spi_cmd_pkg::ST_IDLE: state <= spi_cmd_pkg::ST_CMD;
               spi_cmd_pkg::ST_CMD: begin
                  if (cmd_done) begin
                     state  <= spi_cmd_pkg::ST_DATA;
                     op_q   <= cmd_op;
                     addr_q <= rx_next[`SPI_AW-1:0];
                  end
               end
               spi_cmd_pkg::ST_DATA: begin
                  if (wr_q | load_q)
                     addr_q <= addr_q + 1'b1;  // wraps within 6 bits
               end
               default: state <= spi_cmd_pkg::ST_IDLE;
            endcase
         end
      end
   end

   //####################
   // shift registers

   always_ff @(posedge sclk) begin
      if (sample_edge)
         rx_sh <= rx_next;
      if (data_done)
         wdata_q <= rx_next;                   // held for the wr cycle
      if (ss_s2)
         tx_sh <= '0;
      else if (load_q)
         tx_sh <= bus.rdata;
      else if (shift_edge)
         tx_sh <= lsbfirst ? (tx_sh >> 1) : (tx_sh << 1);
   end

   // miso launched on the shifting edge, low when disabled
   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset)
         miso_q <= 1'b0;
      else if (!spi_en || ss_s2)
         miso_q <= 1'b0;
      else if (shift_edge)
         miso_q <= lsbfirst ? tx_sh[0] : tx_sh[`SPI_DW-1];
   end

   assign spi_miso  = miso_q;
   assign bus.wr    = wr_q;
   assign bus.rd    = load_q;
   assign bus.addr  = addr_q;
   assign bus.wdata = wdata_q;

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/spi_cmd_pkg.sv
hdl/reg_pkg.sv
hdl/reg_bus_if.sv
hdl/spi_slave_io.sv
hdl/reg_file.sv
hdl/apb_host_port.sv
hdl/spi_reg_top.sv
bench/spi_clock_gen.sv
bench/spi_checker.sv
bench/tb_top.sv
